// ==== src/bank_pkg.sv ====
/* Bank game shared definitions
   Widths, game constants, FSM phase encodings and the bundles passed between blocks */
package bank_pkg;

    localparam int BALANCE_WIDTH = 10; // Both balances always sum to 1000
    localparam int KEY_WIDTH = 8;

    typedef logic [BALANCE_WIDTH-1:0] balance_t;
    typedef logic [KEY_WIDTH-1:0] key_t;
    typedef logic player_t;

    localparam balance_t START_BALANCE = 10'd500;
    localparam key_t LFSR_SEED = 8'h5A;
    localparam key_t LFSR_TAPS = 8'hB8; // Taps 8, 6, 5, 4

    localparam int KEY_STEPS = 16;
    localparam int BLACKOUT_PIXELS = 64;
    localparam int CLEAR_CYCLES = 4;
    localparam int KEY_STEP_BITS = $clog2(KEY_STEPS);
    localparam int PIXEL_BITS = $clog2(BLACKOUT_PIXELS);
    localparam int CLEAR_BITS = $clog2(CLEAR_CYCLES);

    typedef enum logic [3:0] {
        INIT1           = 4'b0000,
        INIT2           = 4'b0001,
        STARTUP         = 4'b0010,
        START           = 4'b0011,
        LOAD_PLAYER     = 4'b0100,
        WAIT1           = 4'b0101,
        LOAD_AMOUNT     = 4'b0110,
        WAIT2           = 4'b0111,
        LOAD_KEY        = 4'b1000,
        WAIT3           = 4'b1001,
        TRANSACTION     = 4'b1010,
        RESET_OTHERS    = 4'b1011,
        BLACKOUT_SCREEN = 4'b1100
    } state_t;

    typedef struct packed {
        logic random_init;
        logic init_memory;
        logic load_memory;
        logic load_player;
        logic load_amount;
        logic load_key;
        logic start_transaction;
        logic blackout;
        logic clear_others;
        logic clear_datapath;
    } control_t;

    typedef struct packed {
        balance_t balance;
        key_t key;
    } ledger_entry_t;

    typedef struct packed {
        balance_t balance_p0;
        balance_t balance_p1;
    } display_t;

    typedef enum logic [1:0] {
        RESULT_NONE     = 2'd0,
        RESULT_ACCEPTED = 2'd1,
        RESULT_REJECTED = 2'd2
    } result_t;

endpackage

// ==== src/hex_decoder.sv ====
/* Hex to seven-segment decoder, active low segments */
module hex_decoder (
    input  logic [3:0] hex_digit,
    output logic [6:0] segments
);

    always_comb begin
        case (hex_digit) // Segment order gfedcba
            4'h0: segments = 7'b100_0000;
            4'h1: segments = 7'b111_1001;
            4'h2: segments = 7'b010_0100;
            4'h3: segments = 7'b011_0000;
            4'h4: segments = 7'b001_1001;
            4'h5: segments = 7'b001_0010;
            4'h6: segments = 7'b000_0010;
            4'h7: segments = 7'b111_1000;
            4'h8: segments = 7'b000_0000;
            4'h9: segments = 7'b001_0000;
            4'hA: segments = 7'b000_1000;
            4'hB: segments = 7'b000_0011;
            4'hC: segments = 7'b100_0110;
            4'hD: segments = 7'b010_0001;
            4'hE: segments = 7'b000_0110;
            default: segments = 7'b000_1110;
        endcase
    end

endmodule

// ==== src/key_generator.sv ====
/* Player key generator
   8-bit Fibonacci LFSR stepped through init to produce both private keys */
module key_generator (
    input  logic clock,
    input  logic global_reset,
    input  bank_pkg::control_t control,
    output bank_pkg::key_t current_key,
    output logic done_table_init
);
    import bank_pkg::*;

    key_t lfsr;
    key_t lfsr_next;
    logic [KEY_STEP_BITS-1:0] step_count;
    logic extra_step_done;

    assign lfsr_next = {lfsr[KEY_WIDTH-2:0], ^(lfsr & LFSR_TAPS)};

    always_ff @(posedge clock) begin
        if (global_reset || control.clear_datapath) begin
            lfsr <= LFSR_SEED;
            step_count <= '0;
            extra_step_done <= 1'b0;
        end else if (control.random_init) begin
            lfsr <= lfsr_next;
            step_count <= step_count + 1'b1;
        end else if (control.init_memory && !extra_step_done) begin
            lfsr <= lfsr_next; // Player 1 gets the value after player 0
            extra_step_done <= 1'b1;
        end
    end

    assign current_key = lfsr;
    assign done_table_init = control.random_init &&
                             step_count == KEY_STEP_BITS'(KEY_STEPS - 1);

endmodule

// ==== src/ledger_memory.sv ====
/* Two-player ledger
   Holds balance and key per player, serves the transfer port and latches the display */
module ledger_memory (
    input  logic clock,
    input  logic global_reset,
    input  bank_pkg::control_t control,
    input  bank_pkg::key_t current_key,
    input  bank_pkg::player_t access_player,
    input  logic write_enable,
    input  bank_pkg::ledger_entry_t write_entry,
    output bank_pkg::ledger_entry_t read_entry,
    output logic finished_init,
    output bank_pkg::display_t balance_display
);
    import bank_pkg::*;

    ledger_entry_t entries [0:1];
    player_t init_index;

    // Init walks entry 0 then entry 1
    always_ff @(posedge clock) begin
        if (global_reset || control.clear_datapath) begin
            init_index <= 1'b0;
        end else if (control.init_memory) begin
            init_index <= ~init_index;
        end
    end

    assign finished_init = control.init_memory && init_index;

    always_ff @(posedge clock) begin
        if (control.init_memory) begin
            entries[init_index].balance <= START_BALANCE;
            entries[init_index].key <= current_key;
        end else if (write_enable) begin
            entries[access_player] <= write_entry;
        end
    end

    assign read_entry = entries[access_player]; // Combinational read

    always_ff @(posedge clock) begin
        if (control.load_memory) begin
            balance_display.balance_p0 <= entries[0].balance;
            balance_display.balance_p1 <= entries[1].balance;
        end
    end

endmodule

// ==== src/transaction_engine.sv ====
/* Transfer engine
   Captures payer, amount and key, then reads, checks and writes the two ledger entries */
module transaction_engine (
    input  logic clock,
    input  logic global_reset,
    input  bank_pkg::control_t control,
    input  logic [bank_pkg::BALANCE_WIDTH-1:0] switches,
    input  bank_pkg::ledger_entry_t read_entry,
    output bank_pkg::player_t access_player,
    output logic write_enable,
    output bank_pkg::ledger_entry_t write_entry,
    output logic finished_transaction,
    output bank_pkg::result_t last_result
);
    import bank_pkg::*;

    player_t payer;
    balance_t amount;
    key_t key;
    logic [1:0] step; // 0 read, 1 check, 2 debit, 3 credit
    ledger_entry_t payer_entry;
    logic accept;

    always_ff @(posedge clock) begin
        if (global_reset || control.clear_others || control.clear_datapath) begin
            payer <= 1'b0;
            amount <= '0;
            key <= '0;
        end else begin
            if (control.load_player) payer <= switches[0];
            if (control.load_amount) amount <= switches;
            if (control.load_key) key <= switches[KEY_WIDTH-1:0];
        end
    end

    always_ff @(posedge clock) begin
        if (global_reset || !control.start_transaction) begin
            step <= 2'd0;
        end else begin
            step <= step + 2'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (control.start_transaction && step == 2'd0) payer_entry <= read_entry;
        if (control.start_transaction && step == 2'd1) begin
            accept <= (payer_entry.key == key) && (amount <= payer_entry.balance);
        end
    end

    always_ff @(posedge clock) begin
        if (global_reset || control.clear_datapath) begin
            last_result <= RESULT_NONE;
        end else if (finished_transaction) begin
            last_result <= accept ? RESULT_ACCEPTED : RESULT_REJECTED;
        end
    end

    always_comb begin
        access_player = payer;
        write_enable = 1'b0;
        write_entry = payer_entry;
        if (step == 2'd2) begin
            write_entry.balance = payer_entry.balance - amount;
            write_enable = control.start_transaction && accept;
        end else if (step == 2'd3) begin
            access_player = ~payer; // Payee read-modify-write
            write_entry.balance = read_entry.balance + amount;
            write_entry.key = read_entry.key;
            write_enable = control.start_transaction && accept;
        end
    end

    assign finished_transaction = control.start_transaction && step == 2'd3;

endmodule

// ==== src/screen_blackout.sv ====
/* Screen blackout sweep
   Counts pixels during the blackout phase and flags the last one */
module screen_blackout (
    input  logic clock,
    input  logic global_reset,
    input  bank_pkg::control_t control,
    output logic done_plotting,
    output logic blackout_active
);
    import bank_pkg::*;

    logic [PIXEL_BITS-1:0] pixel_count;

    always_ff @(posedge clock) begin
        if (global_reset || control.clear_others || control.clear_datapath) begin
            pixel_count <= '0;
        end else if (control.blackout) begin
            pixel_count <= pixel_count + 1'b1;
        end
    end

    // High for one cycle on the final pixel
    assign done_plotting = control.blackout &&
                           pixel_count == PIXEL_BITS'(BLACKOUT_PIXELS - 1);
    assign blackout_active = control.blackout;

endmodule

// ==== src/main_control.sv ====
/* Main phase sequencer of the bank game
   Moore FSM stepping through init, operand loading, transfer, blackout and clear */
module main_control (
    input  logic clock,
    input  logic global_reset,
    input  logic start_signal,
    input  logic load_signal,
    input  logic reset_transaction,
    input  logic done_table_init,
    input  logic finished_init,
    input  logic finished_transaction,
    input  logic done_plotting,
    output bank_pkg::control_t control,
    output bank_pkg::state_t state
);
    import bank_pkg::*;

    state_t next_state;
    logic [CLEAR_BITS-1:0] clear_count;

    // Holds Reset_Others for CLEAR_CYCLES, restarts on an abort
    always_ff @(posedge clock) begin
        if (global_reset || reset_transaction || state != RESET_OTHERS) begin
            clear_count <= '0;
        end else begin
            clear_count <= clear_count + 1'b1;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            STARTUP: begin
                if (start_signal) next_state = INIT1;
            end
            INIT1: begin
                if (done_table_init) next_state = INIT2;
            end
            INIT2: begin
                if (finished_init) next_state = RESET_OTHERS;
            end
            START: begin
                if (load_signal) next_state = LOAD_PLAYER;
            end
            LOAD_PLAYER: begin
                if (!load_signal) next_state = WAIT1;
            end
            WAIT1: begin
                if (load_signal) next_state = LOAD_AMOUNT;
            end
            LOAD_AMOUNT: begin
                if (!load_signal) next_state = WAIT2;
            end
            WAIT2: begin
                if (load_signal) next_state = LOAD_KEY;
            end
            LOAD_KEY: begin
                if (!load_signal) next_state = WAIT3;
            end
            WAIT3: begin
                if (start_signal) next_state = TRANSACTION; // Operands complete
            end
            TRANSACTION: begin
                if (finished_transaction) next_state = BLACKOUT_SCREEN;
            end
            BLACKOUT_SCREEN: begin
                if (done_plotting) next_state = RESET_OTHERS;
            end
            RESET_OTHERS: begin
                if (clear_count == CLEAR_BITS'(CLEAR_CYCLES - 1)) next_state = START;
            end
            default: next_state = STARTUP;
        endcase
    end

    // One strobe per phase, wait states drive none
    always_comb begin
        control = '0;
        case (state)
            STARTUP:         control.clear_datapath = 1'b1;
            INIT1:           control.random_init = 1'b1;
            INIT2:           control.init_memory = 1'b1;
            START:           control.load_memory = 1'b1; // Refresh balance display
            LOAD_PLAYER:     control.load_player = 1'b1;
            LOAD_AMOUNT:     control.load_amount = 1'b1;
            LOAD_KEY:        control.load_key = 1'b1;
            TRANSACTION:     control.start_transaction = 1'b1;
            BLACKOUT_SCREEN: control.blackout = 1'b1;
            RESET_OTHERS:    control.clear_others = 1'b1;
            default:         control = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (global_reset) begin
            state <= STARTUP;
        end else if (reset_transaction) begin
            state <= RESET_OTHERS; // Abort from any phase
        end else begin
            state <= next_state;
        end
    end

endmodule

// ==== src/bank_top.sv ====
/* Bank game top level
   Connects the sequencer, key generator, ledger, transfer engine and blackout sweep */
module bank_top (
    input  logic clock,
    input  logic global_reset,
    input  logic start_signal,
    input  logic load_signal,
    input  logic reset_transaction,
    input  logic [bank_pkg::BALANCE_WIDTH-1:0] switches,
    output bank_pkg::display_t balance_display,
    output bank_pkg::result_t last_result,
    output logic [6:0] state_segments,
    output logic blackout_active
);
    import bank_pkg::*;

    control_t control;
    state_t state;
    logic done_table_init;
    logic finished_init;
    logic finished_transaction;
    logic done_plotting;
    key_t current_key;
    player_t access_player;
    logic write_enable;
    ledger_entry_t write_entry;
    ledger_entry_t read_entry;

    main_control main_control_i (
        .clock(clock),
        .global_reset(global_reset),
        .start_signal(start_signal),
        .load_signal(load_signal),
        .reset_transaction(reset_transaction),
        .done_table_init(done_table_init),
        .finished_init(finished_init),
        .finished_transaction(finished_transaction),
        .done_plotting(done_plotting),
        .control(control),
        .state(state)
    );

    key_generator key_generator_i (
        .clock(clock),
        .global_reset(global_reset),
        .control(control),
        .current_key(current_key),
        .done_table_init(done_table_init)
    );

    ledger_memory ledger_memory_i (
        .clock(clock),
        .global_reset(global_reset),
        .control(control),
        .current_key(current_key),
        .access_player(access_player),
        .write_enable(write_enable),
        .write_entry(write_entry),
        .read_entry(read_entry),
        .finished_init(finished_init),
        .balance_display(balance_display)
    );

    transaction_engine transaction_engine_i (
        .clock(clock),
        .global_reset(global_reset),
        .control(control),
        .switches(switches),
        .read_entry(read_entry),
        .access_player(access_player),
        .write_enable(write_enable),
        .write_entry(write_entry),
        .finished_transaction(finished_transaction),
        .last_result(last_result)
    );

    screen_blackout screen_blackout_i (
        .clock(clock),
        .global_reset(global_reset),
        .control(control),
        .done_plotting(done_plotting),
        .blackout_active(blackout_active)
    );

    // Current phase number on the display
    hex_decoder hex_decoder_i (
        .hex_digit(state),
        .segments(state_segments)
    );

endmodule

// ==== verif/bank_assertions.sv ====
/* Sequencer checks
   Load strobes, clear phase length, abort response and transfer completion */
module bank_assertions (
    input logic clock,
    input logic global_reset,
    input logic reset_transaction,
    input logic finished_transaction,
    input bank_pkg::control_t control,
    input bank_pkg::state_t state
);
    timeunit 1ns;
    timeprecision 100ps;
    import bank_pkg::*;

    property one_load_strobe;
        @(posedge clock) disable iff (global_reset)
            $onehot0({control.load_player, control.load_amount, control.load_key});
    endproperty

    // Entry cycle counts as the first clear cycle
    property clear_length;
        @(posedge clock) disable iff (global_reset || reset_transaction)
            ((state == RESET_OTHERS) && ($past(state) != RESET_OTHERS))
                |-> ##(CLEAR_CYCLES - 1) (state == RESET_OTHERS) ##1 (state != RESET_OTHERS);
    endproperty

    property abort_to_clear;
        @(posedge clock) disable iff (global_reset)
            reset_transaction |=> (state == RESET_OTHERS);
    endproperty

    property finish_in_transaction;
        @(posedge clock) disable iff (global_reset)
            finished_transaction |-> (state == TRANSACTION);
    endproperty

    assert property (one_load_strobe) else $error("More than one load strobe high");
    assert property (clear_length) else $error("Clear phase length is wrong");
    assert property (abort_to_clear) else $error("Abort did not reach the clear phase");
    assert property (finish_in_transaction) else $error("Transfer finished outside TRANSACTION");

endmodule

// ==== verif/bank_tb.sv ====
/* Bank game testbench
   Runs the transfers listed in the tests file and checks balances, result and blackout */
module bank_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import bank_pkg::*;

    typedef enum logic [1:0] {OP_INIT, OP_TRANSFER, OP_ABORT} op_t;

    typedef struct packed {
        op_t op;
        player_t player;
        balance_t amount;
        key_t key;
        display_t expected_display;
        result_t expected_result;
    } test_t;

    localparam logic [6:0] START_SEGMENTS = 7'b011_0000; // Digit 3, gfedcba active low
    localparam int PHASE_TIMEOUT = 200;

    logic clock = 1'b0;
    logic global_reset;
    logic start_signal;
    logic load_signal;
    logic reset_transaction;
    logic [BALANCE_WIDTH-1:0] switches;
    display_t balance_display;
    result_t last_result;
    logic [6:0] state_segments;
    logic blackout_active;

    test_t tests[$];
    int error_count = 0;
    int check_count = 0;
    logic tests_loaded = 1'b0;

    bank_top bank_top_i (
        .clock(clock),
        .global_reset(global_reset),
        .start_signal(start_signal),
        .load_signal(load_signal),
        .reset_transaction(reset_transaction),
        .switches(switches),
        .balance_display(balance_display),
        .last_result(last_result),
        .state_segments(state_segments),
        .blackout_active(blackout_active)
    );

    bind main_control bank_assertions bank_assertions_i (
        .clock(clock),
        .global_reset(global_reset),
        .reset_transaction(reset_transaction),
        .finished_transaction(finished_transaction),
        .control(control),
        .state(state)
    );

    always #4 clock = ~clock;

    task automatic check_value(input int actual, input int expected, input string what);
        check_count++;
        if (actual != expected) begin
            error_count++;
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic read_tests();
        int fd;
        int fields;
        int player_value;
        int amount_value;
        int key_value;
        int p0_value;
        int p1_value;
        string line;
        string op_name;
        string result_name;
        test_t entry;
        fd = $fopen("verif/bank_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the tests file verif/bank_tests.txt");
            error_count++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            fields = $sscanf(line, "%s %d %d %h %d %d %s", op_name, player_value,
                             amount_value, key_value, p0_value, p1_value, result_name);
            if (fields == 7) begin // Comment and blank lines fall through
                entry.op = (op_name == "abort") ? OP_ABORT :
                           (op_name == "init") ? OP_INIT : OP_TRANSFER;
                entry.player = player_value[0];
                entry.amount = balance_t'(amount_value);
                entry.key = key_t'(key_value);
                entry.expected_display.balance_p0 = balance_t'(p0_value);
                entry.expected_display.balance_p1 = balance_t'(p1_value);
                entry.expected_result = (result_name == "accepted") ? RESULT_ACCEPTED :
                                        (result_name == "rejected") ? RESULT_REJECTED :
                                        RESULT_NONE;
                tests.push_back(entry);
            end
        end
        $fclose(fd);
    endtask

    task automatic pulse_start();
        start_signal = 1'b1;
        @(negedge clock);
        start_signal = 1'b0;
    endtask

    task automatic load_operand(input logic [BALANCE_WIDTH-1:0] value);
        int hold;
        hold = int'($urandom_range(5, 1));
        switches = value;
        load_signal = 1'b1;
        repeat (hold) @(negedge clock);
        load_signal = 1'b0;
        @(negedge clock); // Capture edge, FSM moves on to its wait state
        switches = '0;
    endtask

    task automatic wait_for_start();
        int cycles;
        cycles = 0;
        while (state_segments != START_SEGMENTS && cycles < PHASE_TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (state_segments != START_SEGMENTS) begin
            $display("Timed out waiting for the start phase");
            error_count++;
        end
        @(negedge clock); // Display latched on the first edge in START
    endtask

    task automatic measure_blackout();
        int cycles;
        int high_cycles;
        cycles = 0;
        high_cycles = 0;
        while (!blackout_active && cycles < PHASE_TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        while (blackout_active) begin
            high_cycles++;
            @(negedge clock);
        end
        check_value(high_cycles, BLACKOUT_PIXELS, "blackout length");
    endtask

    task automatic run_test(input int index);
        test_t t;
        int errors_before;
        string status;
        t = tests[index];
        errors_before = error_count;
        if (t.op == OP_INIT) begin
            pulse_start();
        end else begin
            load_operand(BALANCE_WIDTH'(t.player));
            load_operand(t.amount);
            if (t.op == OP_ABORT) begin
                reset_transaction = 1'b1; // Abort before the key is entered
                @(negedge clock);
                reset_transaction = 1'b0;
            end else begin
                load_operand(BALANCE_WIDTH'(t.key));
                pulse_start();
                measure_blackout();
            end
        end
        wait_for_start();
        check_value(int'(balance_display.balance_p0), int'(t.expected_display.balance_p0),
                    "balance_p0");
        check_value(int'(balance_display.balance_p1), int'(t.expected_display.balance_p1),
                    "balance_p1");
        check_value(int'(last_result), int'(t.expected_result), "last_result");
        status = (error_count == errors_before) ? "ok" : "mismatch";
        $display("test %0d: %s", index, status);
    endtask

    initial begin
        global_reset = 1'b1;
        start_signal = 1'b0;
        load_signal = 1'b0;
        reset_transaction = 1'b0;
        switches = '0;
        void'($urandom(27));
        read_tests();
        tests_loaded = 1'b1;
        repeat (8) @(negedge clock);
        global_reset = 1'b0;
        foreach (tests[i]) begin
            run_test(i);
        end
        $display("%0d tests run, %0d checks, %0d errors", tests.size(), check_count,
                 error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Budget of 200 cycles per test plus margin
    initial begin
        wait (tests_loaded);
        repeat (tests.size() * 200 + 100) @(posedge clock);
        $display("Watchdog expired before the tests finished");
        $display("test failed");
        $finish;
    end

endmodule

// ==== verif/bank_tests.txt ====
# op player amount key(hex) balance_p0 balance_p1 result
# Balances are expected after the test, keys are 2a for player 0 and 54 for player 1
init     0 0    00 500  500 none
transfer 0 100  2a 400  600 accepted
transfer 1 50   54 450  550 accepted
transfer 0 10   54 450  550 rejected
transfer 1 600  54 450  550 rejected
transfer 1 550  54 1000 0   accepted
transfer 1 1    54 1000 0   rejected
abort    0 20   2a 1000 0   rejected
transfer 0 250  2a 750  250 accepted
transfer 1 0    00 750  250 rejected

// ==== vlog.f ====
src/bank_pkg.sv
src/hex_decoder.sv
src/key_generator.sv
src/ledger_memory.sv
src/transaction_engine.sv
src/screen_blackout.sv
src/main_control.sv
src/bank_top.sv
verif/bank_assertions.sv
verif/bank_tb.sv

// ==== Makefile ====
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := bank_tb
FILE_LIST := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(FILE_LIST) $(SOURCES)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(SIM_BIN) verif/bank_tests.txt
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "test failed" $(LOG) || ! grep -q "test passed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
